//--- bench/fsab_system_tb.sv
`timescale 1ns/1ns

module fsab_system_tb import fsab_pkg::*; import mem_pkg::*; ();
	localparam int LIMIT = 2000;	// Cycles allowed per wait
	localparam logic [FSAB_DID_W-1:0] IC_DID = 4'h1;
	localparam logic [FSAB_DID_W-1:0] DC_DID = 4'h2;

	logic clk;
	logic rst_n;
	logic ic_valid;
	logic dc_valid;
	fsab_req_t ic_req;
	fsab_req_t dc_req;
	logic ic_credit;
	logic dc_credit;
	logic rst_core_b;
	logic fsabi_valid;
	logic [FSAB_DID_W-1:0] fsabi_did;
	logic [FSAB_DID_W-1:0] fsabi_subdid;
	logic [FSAB_DATA_W-1:0] fsabi_data;
	int seed;
	int credits [2];	// Indexed by DEV_DC and DEV_IC
	int sent [2];	// Valid cycles driven
	int pulses [2];	// Credit pulses seen
	int errors;
	int passed;
	int failed;
	logic hung;	// Some wait ran out
	logic [67:0] exp_q [2][$];	// Expected {subdid, data} per client
	logic [63:0] ref_mem [int];	// Words written by clients

	fsab_system fsab_system_i (.clk(clk), .rst_n(rst_n),
		.ic_valid(ic_valid), .ic_mode(ic_req.mode), .ic_did(ic_req.did),
		.ic_subdid(ic_req.subdid), .ic_addr(ic_req.addr), .ic_len(ic_req.len),
		.ic_data(ic_req.data), .ic_mask(ic_req.mask), .ic_credit(ic_credit),
		.dc_valid(dc_valid), .dc_mode(dc_req.mode), .dc_did(dc_req.did),
		.dc_subdid(dc_req.subdid), .dc_addr(dc_req.addr), .dc_len(dc_req.len),
		.dc_data(dc_req.data), .dc_mask(dc_req.mask), .dc_credit(dc_credit),
		.rst_core_b(rst_core_b), .fsabi_valid(fsabi_valid), .fsabi_did(fsabi_did),
		.fsabi_subdid(fsabi_subdid), .fsabi_data(fsabi_data));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Current word with the masked bytes of data merged in
	function automatic logic [63:0] ref_word(input int addr, input logic [63:0] data,
		input logic [7:0] mask);
		logic [63:0] w;
		logic [31:0] i32;
		i32 = addr;
		if (ref_mem.exists(addr))
			w = ref_mem[addr];
		else
			w = (addr < PRELOAD_WORDS) ? {PRELOAD_TAG + i32, ~i32} : 'x;	// Boot image
		for (int b = 0; b < 8; b++)
			if (mask[b])
				w[8*b +: 8] = data[8*b +: 8];
		return w;
	endfunction

	task automatic tick(inout int n, input string what);
		@(negedge clk);
		n++;
		if (n > LIMIT && !hung) begin
			hung = 1'b1;
			$display("Timeout after %0d cycles waiting for %s", LIMIT, what);
		end
	endtask

	task automatic drive(input int p, input logic v, input fsab_req_t r);
		if (p == DEV_DC) begin
			dc_valid = v;
			dc_req = r;
		end else begin
			ic_valid = v;
			ic_req = r;
		end
	endtask

	// One valid cycle with a credit in hand
	task automatic send_beat(input int p, input fsab_req_t r);
		int n;
		n = 0;
		while (credits[p] == 0 && !hung) begin
			drive(p, 1'b0, r);
			tick(n, "a client credit");
		end
		if (hung)
			return;
		drive(p, 1'b1, r);
		credits[p]--;
		sent[p]++;
		@(negedge clk);
		drive(p, 1'b0, r);
	endtask

	task automatic write_burst(input int p, input int addr, input int len, input logic [7:0] mask);
		fsab_req_t r;
		logic [31:0] hi;
		logic [31:0] lo;
		r.mode = FSAB_WRITE;
		r.did = (p == DEV_DC) ? DC_DID : IC_DID;
		r.subdid = 4'h0;
		r.addr = 16'(addr);
		r.len = 4'(len);
		r.mask = mask;
		for (int k = 0; k < len; k++) begin
			hi = $random(seed);
			lo = $random(seed);
			r.data = {hi, lo};	// Header repeats while data changes
			ref_mem[addr + k] = ref_word(addr + k, r.data, mask);
			send_beat(p, r);
		end
	endtask

	task automatic read_burst(input int p, input int addr, input int len, input logic [3:0] sub);
		fsab_req_t r;
		r = '{mode: FSAB_READ, did: (p == DEV_DC) ? DC_DID : IC_DID, subdid: sub,
			addr: 16'(addr), len: 4'(len), data: 64'h0, mask: 8'h0};
		for (int k = 0; k < len; k++)
			exp_q[p].push_back({sub, ref_word(addr + k, 64'h0, 8'h0)});	// Before the request
		send_beat(p, r);
	endtask

	task automatic traffic(input int p, input int base);
		int addr;
		int len;
		for (int k = 0; k < 6; k++) begin
			addr = base + {$random(seed)} % 100;
			len = 1 + {$random(seed)} % 4;
			write_burst(p, addr, len, 8'hff);
			read_burst(p, addr, 1 + {$random(seed)} % len, 4'(k));
		end
	endtask

	// All expected returns in
	task automatic wait_idle();
		int n;
		n = 0;
		while ((exp_q[0].size() != 0 || exp_q[1].size() != 0) && !hung)
			tick(n, "the bus to go idle");
	endtask

	task automatic report(input int num, input string name, input int base);
		if (errors == base && !hung) begin
			passed++;
			$display("test %0d %s: ok", num, name);
		end else begin
			failed++;
			$display("test %0d %s: failed", num, name);
		end
	endtask

	always @(posedge clk) begin
		if (dc_credit) begin
			credits[DEV_DC]++;
			pulses[DEV_DC]++;
		end
		if (ic_credit) begin
			credits[DEV_IC]++;
			pulses[DEV_IC]++;
		end
	end

	// Return checker that skips the preload readback
	always @(posedge clk) begin
		logic [67:0] want;
		int p;
		if (rst_n && fsabi_valid && fsabi_did != PRELOAD_DID) begin
			assert (fsabi_did == DC_DID || fsabi_did == IC_DID) else begin
				$display("ERROR %0t: return with unknown did %0h", $time, fsabi_did);
				errors++;
			end
			p = (fsabi_did == DC_DID) ? DEV_DC : DEV_IC;
			assert (exp_q[p].size() > 0) else begin
				$display("Unexpected return at %0t for did %0h", $time, fsabi_did);
				errors++;
			end
			if (exp_q[p].size() > 0) begin
				want = exp_q[p].pop_front();
				assert ({fsabi_subdid, fsabi_data} === want) else begin
					$display("ERROR %0t: did %0h got %h, expected %h", $time, fsabi_did,
						{fsabi_subdid, fsabi_data}, want);
					errors++;
				end
			end
		end
	end

	initial begin
		int base;
		int addr;
		int len;
		int n;
		logic [31:0] r32;
		seed = 32'hefd60923;
		rst_n = 1'b0;
		ic_valid = 1'b0;
		dc_valid = 1'b0;
		ic_req = '0;
		dc_req = '0;
		credits = '{FSAB_CREDITS, FSAB_CREDITS};
		sent = '{0, 0};
		pulses = '{0, 0};
		errors = 0;
		passed = 0;
		failed = 0;
		hung = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		base = errors;
		rst_n = 1'b1;
		@(negedge clk);
		assert (!ic_credit && !dc_credit && !fsabi_valid && !rst_core_b) else begin
			$display("ERROR %0t: outputs not low after reset", $time);
			errors++;
		end
		n = 0;
		while (!rst_core_b && !hung)
			tick(n, "rst_core_b");
		report(1, "reset and preload", base);
		base = errors;
		read_burst(DEV_IC, 0, 8, 4'h3);
		read_burst(DEV_IC, 8, 8, 4'h4);
		wait_idle();
		report(2, "boot image readback", base);
		base = errors;
		addr = {$random(seed)} % PRELOAD_WORDS;	// Known old word
		r32 = $random(seed);
		write_burst(DEV_DC, addr, 1, r32[7:0]);
		read_burst(DEV_DC, addr, 1, 4'h5);
		wait_idle();
		report(3, "masked write", base);
		base = errors;
		addr = 128 + {$random(seed)} % 120;
		len = 1 + {$random(seed)} % 8;
		write_burst(DEV_DC, addr, len, 8'hff);
		read_burst(DEV_DC, addr, len, 4'h6);
		wait_idle();
		report(4, "write and read burst", base);
		base = errors;
		fork
			traffic(DEV_IC, 16);
			traffic(DEV_DC, 128);
		join
		wait_idle();
		report(5, "concurrent clients", base);
		base = errors;
		for (int p = 0; p < 2; p++) begin
			assert (pulses[p] == sent[p] && credits[p] == FSAB_CREDITS) else begin
				$display("ERROR %0t: port %0d sent %0d, credits back %0d", $time, p,
					sent[p], pulses[p]);
				errors++;
			end
		end
		report(6, "credit accounting", base);
		$display("tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
		if (errors == 0 && !hung)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- list.f
logic/fsab_pkg.sv
logic/mem_pkg.sv
logic/fsab_if.sv
logic/fsab_fifo.sv
logic/fsab_credit_counter.sv
logic/fsab_preload.sv
logic/fsab_arbiter.sv
logic/fsab_memory.sv
logic/fsab_system.sv
bench/fsab_system_tb.sv

//--- logic/fsab_arbiter.sv
`timescale 1ns/1ns

module fsab_arbiter import fsab_pkg::*; (
	input logic clk,
	input logic rst_n,
	fsab_req_if.arbiter dev [FSAB_DEVICES],
	fsab_req_if.requester mem
);
	fsab_req_t head [FSAB_DEVICES];	// FIFO heads
	logic [FSAB_DEVICES-1:0] empty;
	logic [FSAB_DEVICES-1:0] pop;
	logic [FSAB_DEVICES-1:0] credit_q;	// Refund pulse a cycle after pop
	logic [FSAB_DEV_W-1:0] sel;
	logic [FSAB_DEV_W-1:0] last_q;	// Last granted, also burst owner
	logic found;
	logic grant;
	logic mem_can_send;
	logic locked_q;	// Inside a write burst
	logic [FSAB_LEN_W-1:0] beats_q;	// Write beats still to go
	logic out_valid_q;
	fsab_req_t out_q;

	for (genvar i = 0; i < FSAB_DEVICES; i++) begin : g_dev
		fsab_req_t in_req;

		assign in_req = '{mode: dev[i].mode, did: dev[i].did, subdid: dev[i].subdid,
			addr: dev[i].addr, len: dev[i].len, data: dev[i].data, mask: dev[i].mask};

		fsab_fifo #(.payload_t(fsab_req_t)) fifo_i (
			.clk(clk),
			.rst_n(rst_n),
			.push(dev[i].valid),
			.push_data(in_req),
			.pop(pop[i]),
			.pop_data(head[i]),
			.empty(empty[i]),
			.full()
		);

		assign pop[i] = grant && (sel == FSAB_DEV_W'(i));
		assign dev[i].credit = credit_q[i];
	end

	fsab_credit_counter mem_credit_i (
		.clk(clk),
		.rst_n(rst_n),
		.spend(grant),	// Counted at grant, valid follows next cycle
		.refund(mem.credit),
		.can_send(mem_can_send)
	);

	always_comb begin
		int idx;
		idx = 0;
		found = 1'b0;
		sel = last_q;
		if (locked_q) begin
			found = !empty[last_q];	// Wait for the burst owner
		end else begin
			for (int k = 1; k <= FSAB_DEVICES; k++) begin
				idx = (int'(last_q) + k) % FSAB_DEVICES;	// Round-robin from last
				if (!found && !empty[idx]) begin
					found = 1'b1;
					sel = FSAB_DEV_W'(idx);
				end
			end
		end
	end

	assign grant = found && mem_can_send;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_q <= FSAB_DEV_W'(FSAB_DEVICES - 1);	// DC first
			locked_q <= 1'b0;
			beats_q <= '0;
			credit_q <= '0;
			out_valid_q <= 1'b0;
		end else begin
			credit_q <= pop;
			out_valid_q <= grant;
			if (grant) begin
				last_q <= sel;
				if (locked_q) begin
					locked_q <= (beats_q != FSAB_LEN_W'(1));
					beats_q <= beats_q - 1'b1;
				end else if ((head[sel].mode == FSAB_WRITE) && (head[sel].len > FSAB_LEN_W'(1))) begin
					locked_q <= 1'b1;	// Hold grant for the rest
					beats_q <= head[sel].len - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (grant)
			out_q <= head[sel];
	end

	assign mem.valid = out_valid_q;
	assign mem.mode = out_q.mode;
	assign mem.did = out_q.did;
	assign mem.subdid = out_q.subdid;
	assign mem.addr = out_q.addr;
	assign mem.len = out_q.len;
	assign mem.data = out_q.data;
	assign mem.mask = out_q.mask;

	// Beats under lock carry the header of the burst they continue
	a_burst_whole: assert property (@(posedge clk) disable iff (!rst_n)
		(grant && locked_q) |-> (head[sel].mode == FSAB_WRITE) &&
			(head[sel].did == out_q.did) && (head[sel].addr == out_q.addr))
		else $error("write burst interleaved on slot %0d", sel);

endmodule

//--- logic/fsab_credit_counter.sv
`timescale 1ns/1ns

module fsab_credit_counter import mem_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic spend,	// Sender used a credit
	input logic refund,	// Receiver handed one back
	output logic can_send
);
	logic [CREDIT_W-1:0] count_q;	// Free slots at the receiver

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			count_q <= CREDIT_W'(FSAB_CREDITS);	// Receiver FIFO starts empty
		else if (spend && !refund)
			count_q <= count_q - 1'b1;
		else if (refund && !spend)
			count_q <= count_q + 1'b1;
	end

	assign can_send = (count_q != '0);

	// Sender logic must honor can_send
	a_no_overspend: assert property (@(posedge clk) disable iff (!rst_n) spend |-> can_send)
		else $error("credit spent with none left");
	// Receiver never frees more than was sent
	a_no_overrefund: assert property (@(posedge clk) disable iff (!rst_n)
		!(refund && !spend && count_q == CREDIT_W'(FSAB_CREDITS)))
		else $error("credit returned past the limit");

endmodule

//--- logic/fsab_fifo.sv
`timescale 1ns/1ns

module fsab_fifo import mem_pkg::*; #(
	parameter type payload_t = logic,
	parameter int DEPTH = FSAB_CREDITS
) (
	input logic clk,
	input logic rst_n,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t pop_data,
	output logic empty,
	output logic full
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;	// Pointer width

	payload_t slots [DEPTH];	// Payload storage, no reset
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [AW:0] count_q;	// One extra bit to tell full

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push)
				wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: ;	// Both or neither leave it
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			slots[wr_ptr_q] <= push_data;
	end

	assign pop_data = slots[rd_ptr_q];	// Head, valid while not empty
	assign empty = (count_q == '0);
	assign full = (count_q == (AW + 1)'(DEPTH));

	// Sender must have held a credit for every push
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
		else $error("push into full FIFO");
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
		else $error("pop from empty FIFO");

endmodule

//--- logic/fsab_if.sv
`timescale 1ns/1ns

interface fsab_req_if import fsab_pkg::*; ();
	logic valid;	// One request cycle, costs one credit
	fsab_mode_t mode;
	logic [FSAB_DID_W-1:0] did;
	logic [FSAB_DID_W-1:0] subdid;
	logic [FSAB_ADDR_W-1:0] addr;
	logic [FSAB_LEN_W-1:0] len;
	logic [FSAB_DATA_W-1:0] data;
	logic [FSAB_MASK_W-1:0] mask;
	logic credit;	// Pulse per freed FIFO slot

	modport requester (
		output valid, mode, did, subdid, addr, len, data, mask,
		input credit
	);
	modport arbiter (
		input valid, mode, did, subdid, addr, len, data, mask,
		output credit
	);
endinterface

interface fsab_ret_if import fsab_pkg::*; ();
	logic valid;	// No back-pressure, everyone sees every beat
	logic [FSAB_DID_W-1:0] did;
	logic [FSAB_DID_W-1:0] subdid;
	logic [FSAB_DATA_W-1:0] data;

	modport memory (output valid, did, subdid, data);
	modport listener (input valid, did, subdid, data);
endinterface

//--- logic/fsab_memory.sv
`timescale 1ns/1ns

module fsab_memory import fsab_pkg::*; import mem_pkg::*; (
	input logic clk,
	input logic rst_n,
	fsab_req_if.arbiter req,
	fsab_ret_if.memory ret
);
	logic [FSAB_DATA_W-1:0] mem_q [1 << MEM_ADDR_W];	// Undefined until written
	fsab_req_t in_req;
	fsab_req_t head;
	logic empty;
	logic pop;
	logic credit_q;
	logic [FSAB_LEN_W-1:0] rd_left_q;	// Read beats still to return
	logic [FSAB_LEN_W-1:0] wr_beat_q;	// Beat index inside write burst
	logic [MEM_ADDR_W-1:0] wr_addr;
	logic [MEM_ADDR_W-1:0] rd_addr_q;
	logic [FSAB_DID_W-1:0] rd_did_q;
	logic [FSAB_DID_W-1:0] rd_subdid_q;
	logic ret_valid_q;
	logic [FSAB_DATA_W-1:0] ret_data_q;

	assign in_req = '{mode: req.mode, did: req.did, subdid: req.subdid,
		addr: req.addr, len: req.len, data: req.data, mask: req.mask};

	fsab_fifo #(.payload_t(fsab_req_t)) fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.push(req.valid),
		.push_data(in_req),
		.pop(pop),
		.pop_data(head),
		.empty(empty),
		.full()
	);

	assign pop = !empty && (rd_left_q == '0);	// Hold queue while streaming
	assign wr_addr = head.addr[MEM_ADDR_W-1:0] + MEM_ADDR_W'(wr_beat_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_left_q <= '0;
			wr_beat_q <= '0;
			credit_q <= 1'b0;
			ret_valid_q <= 1'b0;
		end else begin
			credit_q <= pop;	// One credit per popped entry
			ret_valid_q <= (rd_left_q != '0);
			if (rd_left_q != '0)
				rd_left_q <= rd_left_q - 1'b1;
			else if (pop && (head.mode == FSAB_READ))
				rd_left_q <= head.len;
			if (pop && (head.mode == FSAB_WRITE))
				wr_beat_q <= (wr_beat_q == head.len - 1'b1) ? '0 : wr_beat_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (pop && (head.mode == FSAB_WRITE)) begin
			for (int b = 0; b < FSAB_MASK_W; b++) begin
				if (head.mask[b])
					mem_q[wr_addr][8*b +: 8] <= head.data[8*b +: 8];	// Masked byte
			end
		end
		if (pop && (head.mode == FSAB_READ)) begin
			rd_addr_q <= head.addr[MEM_ADDR_W-1:0];
			rd_did_q <= head.did;
			rd_subdid_q <= head.subdid;
		end else if (rd_left_q != '0) begin
			rd_addr_q <= rd_addr_q + 1'b1;	// Next beat of the burst
		end
		if (rd_left_q != '0)
			ret_data_q <= mem_q[rd_addr_q];
	end

	assign req.credit = credit_q;
	assign ret.valid = ret_valid_q;
	assign ret.did = rd_did_q;	// Stable until next read pops
	assign ret.subdid = rd_subdid_q;
	assign ret.data = ret_data_q;

endmodule

//--- logic/fsab_pkg.sv
package fsab_pkg;

	localparam int FSAB_ADDR_W = 16;	// Word address
	localparam int FSAB_DATA_W = 64;	// One beat
	localparam int FSAB_MASK_W = 8;	// Byte enables, set bit writes
	localparam int FSAB_LEN_W = 4;	// Burst of 1 to 8 beats
	localparam int FSAB_DID_W = 4;	// Device id and subdid

	localparam int FSAB_DEVICES = 3;	// Requesters on the arbiter
	localparam int FSAB_DEV_W = $clog2(FSAB_DEVICES);	// Grant index width
	localparam int DEV_DC = 0;	// Arbiter slots
	localparam int DEV_IC = 1;
	localparam int DEV_PRE = 2;

	typedef enum logic [1:0] {
		FSAB_NOP = 2'd0,
		FSAB_READ = 2'd1,
		FSAB_WRITE = 2'd2
	} fsab_mode_t;

	typedef struct packed {
		fsab_mode_t mode;
		logic [FSAB_DID_W-1:0] did;
		logic [FSAB_DID_W-1:0] subdid;
		logic [FSAB_ADDR_W-1:0] addr;	// Burst base, same on every beat
		logic [FSAB_LEN_W-1:0] len;
		logic [FSAB_DATA_W-1:0] data;
		logic [FSAB_MASK_W-1:0] mask;
	} fsab_req_t;

	typedef struct packed {
		logic [FSAB_DID_W-1:0] did;
		logic [FSAB_DID_W-1:0] subdid;
		logic [FSAB_DATA_W-1:0] data;
	} fsab_ret_t;

endpackage

//--- logic/fsab_preload.sv
`timescale 1ns/1ns

module fsab_preload import fsab_pkg::*; import mem_pkg::*; (
	input logic clk,
	input logic rst_n,
	fsab_req_if.requester req,
	fsab_ret_if.listener ret,
	output logic rst_core_b
);
	typedef enum logic [1:0] {WRITE, READ, WAIT, DONE} state_t;

	state_t state_q;
	logic [PRELOAD_IDX_W-1:0] word_q;	// Image word being sent
	logic can_send;
	logic sending;
	logic ret_ok;

	fsab_credit_counter credit_i (
		.clk(clk),
		.rst_n(rst_n),
		.spend(sending),
		.refund(req.credit),
		.can_send(can_send)
	);

	assign sending = ((state_q == WRITE) || (state_q == READ)) && can_send;	// Stall on no credit

	assign req.valid = sending;
	assign req.mode = (state_q == WRITE) ? FSAB_WRITE :
		(state_q == READ) ? FSAB_READ : FSAB_NOP;
	assign req.did = PRELOAD_DID;
	assign req.subdid = '0;
	assign req.addr = (state_q == READ) ? FSAB_ADDR_W'(PRELOAD_LAST) :
		FSAB_ADDR_W'(word_q & ~PRELOAD_IDX_W'(PRELOAD_BURST - 1));	// Burst base held
	assign req.len = (state_q == READ) ? FSAB_LEN_W'(1) : FSAB_LEN_W'(PRELOAD_BURST);
	assign req.data = preload_word(FSAB_ADDR_W'(word_q));
	assign req.mask = (state_q == WRITE) ? '1 : '0;	// Full words only

	// Verify read return for us
	assign ret_ok = (ret.did == PRELOAD_DID) && (ret.subdid == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= WRITE;
			word_q <= '0;
		end else begin
			case (state_q)
				WRITE: if (sending) begin
					if (word_q == PRELOAD_LAST)
						state_q <= READ;	// Image out, read back last word
					else
						word_q <= word_q + 1'b1;
				end
				READ: if (sending)
					state_q <= WAIT;
				WAIT: if (ret.valid && ret_ok) begin
					if (ret.data == preload_word(FSAB_ADDR_W'(PRELOAD_LAST))) begin
						state_q <= DONE;
					end else begin
						state_q <= WRITE;	// Bad readback, write image again
						word_q <= '0;
					end
				end
				default: ;	// DONE holds until reset
			endcase
		end
	end

	assign rst_core_b = (state_q == DONE);	// Core out of reset

endmodule

//--- logic/fsab_system.sv
`timescale 1ns/1ns

module fsab_system import fsab_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic ic_valid,
	input fsab_mode_t ic_mode,
	input logic [FSAB_DID_W-1:0] ic_did,
	input logic [FSAB_DID_W-1:0] ic_subdid,
	input logic [FSAB_ADDR_W-1:0] ic_addr,
	input logic [FSAB_LEN_W-1:0] ic_len,
	input logic [FSAB_DATA_W-1:0] ic_data,
	input logic [FSAB_MASK_W-1:0] ic_mask,
	output logic ic_credit,
	input logic dc_valid,
	input fsab_mode_t dc_mode,
	input logic [FSAB_DID_W-1:0] dc_did,
	input logic [FSAB_DID_W-1:0] dc_subdid,
	input logic [FSAB_ADDR_W-1:0] dc_addr,
	input logic [FSAB_LEN_W-1:0] dc_len,
	input logic [FSAB_DATA_W-1:0] dc_data,
	input logic [FSAB_MASK_W-1:0] dc_mask,
	output logic dc_credit,
	output logic rst_core_b,
	output logic fsabi_valid,
	output logic [FSAB_DID_W-1:0] fsabi_did,
	output logic [FSAB_DID_W-1:0] fsabi_subdid,
	output logic [FSAB_DATA_W-1:0] fsabi_data
);
	fsab_req_if dev_if [FSAB_DEVICES] ();	// One per arbiter slot
	fsab_req_if mem_if ();	// Arbiter to memory
	fsab_ret_if ret_if ();	// Shared return bus

	assign dev_if[DEV_IC].valid = ic_valid;
	assign dev_if[DEV_IC].mode = ic_mode;
	assign dev_if[DEV_IC].did = ic_did;
	assign dev_if[DEV_IC].subdid = ic_subdid;
	assign dev_if[DEV_IC].addr = ic_addr;
	assign dev_if[DEV_IC].len = ic_len;
	assign dev_if[DEV_IC].data = ic_data;
	assign dev_if[DEV_IC].mask = ic_mask;
	assign ic_credit = dev_if[DEV_IC].credit;

	assign dev_if[DEV_DC].valid = dc_valid;
	assign dev_if[DEV_DC].mode = dc_mode;
	assign dev_if[DEV_DC].did = dc_did;
	assign dev_if[DEV_DC].subdid = dc_subdid;
	assign dev_if[DEV_DC].addr = dc_addr;
	assign dev_if[DEV_DC].len = dc_len;
	assign dev_if[DEV_DC].data = dc_data;
	assign dev_if[DEV_DC].mask = dc_mask;
	assign dc_credit = dev_if[DEV_DC].credit;

	fsab_preload preload_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(dev_if[DEV_PRE]),
		.ret(ret_if),
		.rst_core_b(rst_core_b)
	);

	fsab_arbiter arbiter_i (.clk(clk), .rst_n(rst_n), .dev(dev_if), .mem(mem_if));

	fsab_memory memory_i (.clk(clk), .rst_n(rst_n), .req(mem_if), .ret(ret_if));

	assign fsabi_valid = ret_if.valid;	// Clients filter by did
	assign fsabi_did = ret_if.did;
	assign fsabi_subdid = ret_if.subdid;
	assign fsabi_data = ret_if.data;

endmodule

//--- logic/mem_pkg.sv
package mem_pkg;

	import fsab_pkg::*;

	localparam int MEM_ADDR_W = 8;	// 256 words, low address bits only
	localparam int FSAB_CREDITS = 4;	// FIFO depth per receiver
	localparam int CREDIT_W = $clog2(FSAB_CREDITS + 1);	// Holds 0 to FSAB_CREDITS

	localparam int PRELOAD_WORDS = 16;	// Boot image size
	localparam int PRELOAD_BURST = 8;	// Beats per image burst
	localparam int PRELOAD_IDX_W = $clog2(PRELOAD_WORDS);
	localparam logic [PRELOAD_IDX_W-1:0] PRELOAD_LAST = PRELOAD_IDX_W'(PRELOAD_WORDS - 1);
	localparam logic [31:0] PRELOAD_TAG = 32'hb0070000;
	localparam logic [FSAB_DID_W-1:0] PRELOAD_DID = 4'hf;

	// Image word i is tag plus i over inverted i
	function automatic logic [FSAB_DATA_W-1:0] preload_word(input logic [FSAB_ADDR_W-1:0] idx);
		logic [31:0] i32;
		i32 = 32'(idx);
		return {PRELOAD_TAG + i32, ~i32};
	endfunction

endpackage

//--- run.sh
#!/bin/sh
# Verilator build of the bench, then the run decides by the pass line
verilator --binary --assert -f list.f --top-module fsab_system_tb -o fsab_sim \
	&& ./obj_dir/fsab_sim | tee /dev/stderr | grep -F -q "=== PASS ===" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
